//--- pcs8g_macros.svh
// pcs8g CSR sizes and register map
// lane count, field widths, synchronizer depth and bus addresses
`ifndef PCS8G_MACROS_SVH
`define PCS8G_MACROS_SVH

////////////////////
// sizes
`define PCS8G_LANES        4   // transceiver lanes behind the lane index
`define PCS8G_WORDS        2   // per-word status bits, 8b/10b decoder outputs
`define PCS8G_BOUNDARY_W   5   // bitslip boundary field
`define PCS8G_LANE_SEL_W   5   // lane index register
`define PCS8G_SYNC_STAGES  2   // flops per synchronizer chain

////////////////////
// register addresses, bus word granularity
`define PCS8G_ADDR_LANE          8'h08  // lane index for indirection
`define PCS8G_ADDR_RX_STATUS     8'h09  // ro
`define PCS8G_ADDR_TX_STATUS     8'h0A  // ro
`define PCS8G_ADDR_TX_CTRL       8'h0B  // rw, per lane
`define PCS8G_ADDR_RX_CTRL       8'h0C  // rw, per lane
`define PCS8G_ADDR_RX_WA_CTRL    8'h0D  // rw, per lane
`define PCS8G_ADDR_RX_WA_STATUS  8'h0E  // ro

`endif

//--- pcs8g_pkg.sv
// pcs8g CSR types
// per-lane control and status records and the decoded views of a bus word
`include "pcs8g_macros.svh"

package pcs8g_pkg;

  typedef logic [`PCS8G_LANE_SEL_W-1:0] lane_sel_t;

  // one lane's controls as held in the bus domain
  typedef struct packed {
    logic                         tx_invpolarity;
    logic [`PCS8G_BOUNDARY_W-1:0] tx_boundary;
    logic                         rx_invpolarity;
    logic                         rx_enapatternalign;
    logic                         rx_bitreversal;
    logic                         rx_bytereversal;
    logic                         rx_bitslip;
  } lane_ctrl_t;

  // one lane's status after the clk synchronizer
  typedef struct packed {
    logic                         rx_fifo_error;
    logic                         tx_fifo_error;
    logic [`PCS8G_BOUNDARY_W-1:0] rx_boundary;
    logic [`PCS8G_WORDS-1:0]      rx_errdetect;
    logic [`PCS8G_WORDS-1:0]      rx_syncstatus;
    logic [`PCS8G_WORDS-1:0]      rx_disperr;
    logic [`PCS8G_WORDS-1:0]      rx_patterndetect;
    logic                         rlv;
  } lane_status_t;

  ////////////////////
  // register layouts, msb first, all 32 bits wide
  typedef struct packed {
    logic [31-`PCS8G_LANE_SEL_W:0] rsvd;
    lane_sel_t                     lane;        // 4:0
  } lane_word_t;

  // rx status and tx control share this shape
  typedef struct packed {
    logic [30-`PCS8G_BOUNDARY_W:0] rsvd;
    logic [`PCS8G_BOUNDARY_W-1:0]  boundary;    // 5:1
    logic                          bit0;        // fifo error or invpolarity
  } bnd_word_t;

  typedef struct packed {
    logic [30:0] rsvd;
    logic        bit0;                          // fifo error or invpolarity
  } flag_word_t;

  typedef struct packed {
    logic [27:0] rsvd;
    logic        bitslip;                       // 3
    logic        bytereversal;                  // 2
    logic        bitreversal;                   // 1
    logic        enapatternalign;               // 0
  } wa_ctrl_word_t;

  typedef struct packed {
    logic [14:0] rsvd;
    logic        rlv;                           // 16
    logic [3:0]  patterndetect;                 // 15:12
    logic [3:0]  disperr;                       // 11:8
    logic [3:0]  syncstatus;                    // 7:4
    logic [3:0]  errdetect;                     // 3:0
  } wa_status_word_t;

  typedef union packed {
    logic [31:0]     raw;
    lane_word_t      lane;
    bnd_word_t       rx_status;
    flag_word_t      tx_status;
    bnd_word_t       tx_ctrl;
    flag_word_t      rx_ctrl;
    wa_ctrl_word_t   wa_ctrl;
    wa_status_word_t wa_status;
  } csr_word_u;

endpackage

//--- pcs8g_if.sv
// pcs8g CSR internal links
// control array to the domain crossing, lane select and status from the sync block
`include "pcs8g_macros.svh"

////////////////////
// register file -> tx/rx domain crossing
interface pcs8g_ctrl_if import pcs8g_pkg::*; ();

  lane_ctrl_t [`PCS8G_LANES-1:0] lane;  // one entry per lane, bus clock domain

  modport regs (output lane);
  modport cdc  (input  lane);

endinterface

////////////////////
// register file <-> status synchronizer
interface pcs8g_status_if import pcs8g_pkg::*; ();

  lane_sel_t    lane_sel;   // current lane index, unchecked
  lane_status_t lane_st;    // synchronized status of that lane

  modport regs (output lane_sel, input  lane_st);
  modport sync (input  lane_sel, output lane_st);

endinterface

//--- pcs8g_csr_regs.sv
// pcs8g register file
// address decode, lane index, per-lane controls and the registered read mux
`include "pcs8g_macros.svh"

module pcs8g_csr_regs import pcs8g_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic [7:0]  address,
  input  logic        read,
  input  logic        write,
  input  logic [31:0] writedata,
  output logic [31:0] readdata,
  pcs8g_ctrl_if.regs   ctrl,
  pcs8g_status_if.regs status
);

  lane_sel_t                     lane_sel;   // indirection index
  lane_ctrl_t [`PCS8G_LANES-1:0] ctrl_q;     // all lanes' controls
  lane_ctrl_t                    sel_ctrl;   // controls of the indexed lane
  logic                          lane_ok;    // index names a real lane
  csr_word_u                     wr_word;
  csr_word_u                     rd_word;

  assign wr_word  = writedata;
  assign lane_ok  = (lane_sel < `PCS8G_LANES);
  assign sel_ctrl = lane_ok ? ctrl_q[lane_sel] : '0;  // out of range reads as zero

  assign ctrl.lane       = ctrl_q;
  assign status.lane_sel = lane_sel;

  ////////////////////
  // writes
  // only the indexed lane's entry is touched, other lanes keep their bits
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lane_sel <= '0;
      ctrl_q   <= '0;
    end else if (write) begin
      case (address)
        `PCS8G_ADDR_LANE: lane_sel <= wr_word.lane.lane;
        `PCS8G_ADDR_TX_CTRL: begin
          if (lane_ok) begin
            ctrl_q[lane_sel].tx_invpolarity <= wr_word.tx_ctrl.bit0;
            ctrl_q[lane_sel].tx_boundary    <= wr_word.tx_ctrl.boundary;
          end
        end
        `PCS8G_ADDR_RX_CTRL: begin
          if (lane_ok)
            ctrl_q[lane_sel].rx_invpolarity <= wr_word.rx_ctrl.bit0;
        end
        `PCS8G_ADDR_RX_WA_CTRL: begin
          if (lane_ok) begin
            ctrl_q[lane_sel].rx_enapatternalign <= wr_word.wa_ctrl.enapatternalign;
            ctrl_q[lane_sel].rx_bitreversal     <= wr_word.wa_ctrl.bitreversal;
            ctrl_q[lane_sel].rx_bytereversal    <= wr_word.wa_ctrl.bytereversal;
            ctrl_q[lane_sel].rx_bitslip         <= wr_word.wa_ctrl.bitslip;
          end
        end
        default: ;  // status and unmapped addresses ignore writes
      endcase
    end
  end

  ////////////////////
  // read word assembly
  always_comb begin
    rd_word = '0;
    case (address)
      `PCS8G_ADDR_LANE: rd_word.lane.lane = lane_sel;
      `PCS8G_ADDR_RX_STATUS: begin
        rd_word.rx_status.bit0     = status.lane_st.rx_fifo_error;
        rd_word.rx_status.boundary = status.lane_st.rx_boundary;
      end
      `PCS8G_ADDR_TX_STATUS: rd_word.tx_status.bit0 = status.lane_st.tx_fifo_error;
      `PCS8G_ADDR_TX_CTRL: begin
        rd_word.tx_ctrl.bit0     = sel_ctrl.tx_invpolarity;
        rd_word.tx_ctrl.boundary = sel_ctrl.tx_boundary;
      end
      `PCS8G_ADDR_RX_CTRL: rd_word.rx_ctrl.bit0 = sel_ctrl.rx_invpolarity;
      `PCS8G_ADDR_RX_WA_CTRL: begin
        rd_word.wa_ctrl.enapatternalign = sel_ctrl.rx_enapatternalign;
        rd_word.wa_ctrl.bitreversal     = sel_ctrl.rx_bitreversal;
        rd_word.wa_ctrl.bytereversal    = sel_ctrl.rx_bytereversal;
        rd_word.wa_ctrl.bitslip         = sel_ctrl.rx_bitslip;
      end
      `PCS8G_ADDR_RX_WA_STATUS: begin
        // per-word fields sit at the bottom of each nibble
        rd_word.wa_status.errdetect     = 4'(status.lane_st.rx_errdetect);
        rd_word.wa_status.syncstatus    = 4'(status.lane_st.rx_syncstatus);
        rd_word.wa_status.disperr       = 4'(status.lane_st.rx_disperr);
        rd_word.wa_status.patterndetect = 4'(status.lane_st.rx_patterndetect);
        rd_word.wa_status.rlv           = status.lane_st.rlv;
      end
      default: rd_word.raw = '1;  // unmapped
    endcase
  end

  // registered read, no wait state; holds until the next read
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      readdata <= '0;
    else if (read)
      readdata <= rd_word.raw;
  end

endmodule

//--- pcs8g_status_sync.sv
// pcs8g status synchronizer
// brings the transceiver status into clk and picks out the indexed lane
`include "pcs8g_macros.svh"

module pcs8g_status_sync import pcs8g_pkg::*; (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic [`PCS8G_LANES*`PCS8G_WORDS-1:0]      rx_patterndetect,
  input  logic [`PCS8G_LANES*`PCS8G_WORDS-1:0]      rx_syncstatus,
  input  logic [`PCS8G_LANES*`PCS8G_WORDS-1:0]      rx_errdetect,
  input  logic [`PCS8G_LANES*`PCS8G_WORDS-1:0]      rx_disperr,
  input  logic [`PCS8G_LANES-1:0]                   rx_phase_comp_fifo_error,
  input  logic [`PCS8G_LANES-1:0]                   tx_phase_comp_fifo_error,
  input  logic [`PCS8G_LANES-1:0]                   rlv,
  input  logic [`PCS8G_LANES*`PCS8G_BOUNDARY_W-1:0] rx_bitslipboundaryselectout,
  pcs8g_status_if.sync                            status
);

  lane_status_t [`PCS8G_LANES-1:0] raw_st;                      // async, lane grouped
  lane_status_t [`PCS8G_LANES-1:0] sync_q [`PCS8G_SYNC_STAGES]; // [0] sees raw input

  // pure rewiring of the packed inputs, no logic before the first flop
  always_comb begin
    for (int i = 0; i < `PCS8G_LANES; i++) begin
      raw_st[i].rx_fifo_error    = rx_phase_comp_fifo_error[i];
      raw_st[i].tx_fifo_error    = tx_phase_comp_fifo_error[i];
      raw_st[i].rx_boundary      = rx_bitslipboundaryselectout[i*`PCS8G_BOUNDARY_W +:
                                                               `PCS8G_BOUNDARY_W];
      raw_st[i].rx_errdetect     = rx_errdetect[i*`PCS8G_WORDS +: `PCS8G_WORDS];
      raw_st[i].rx_syncstatus    = rx_syncstatus[i*`PCS8G_WORDS +: `PCS8G_WORDS];
      raw_st[i].rx_disperr       = rx_disperr[i*`PCS8G_WORDS +: `PCS8G_WORDS];
      raw_st[i].rx_patterndetect = rx_patterndetect[i*`PCS8G_WORDS +: `PCS8G_WORDS];
      raw_st[i].rlv              = rlv[i];
    end
  end

  ////////////////////
  // clk synchronizer chain, each bit independent
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int s = 0; s < `PCS8G_SYNC_STAGES; s++)
        sync_q[s] <= '0;
    end else begin
      sync_q[0] <= raw_st;
      for (int s = 1; s < `PCS8G_SYNC_STAGES; s++)
        sync_q[s] <= sync_q[s-1];
    end
  end

  // lane select, an index past the last lane matches nothing and gives zero
  always_comb begin
    status.lane_st = '0;
    for (int i = 0; i < `PCS8G_LANES; i++) begin
      if (status.lane_sel == i)
        status.lane_st = sync_q[`PCS8G_SYNC_STAGES-1][i];
    end
  end

endmodule

//--- pcs8g_ctrl_cdc.sv
// pcs8g control domain crossing
// moves the bus-domain control registers into the tx_clk and rx_clk domains
`include "pcs8g_macros.svh"

module pcs8g_ctrl_cdc import pcs8g_pkg::*; (
  input  logic                                    tx_clk,
  input  logic                                    rx_clk,
  input  logic                                    reset,
  pcs8g_ctrl_if.cdc                               ctrl,
  output logic [`PCS8G_LANES-1:0]                   csr_tx_invpolarity,
  output logic [`PCS8G_LANES*`PCS8G_BOUNDARY_W-1:0] csr_tx_bitslipboundaryselect,
  output logic [`PCS8G_LANES-1:0]                   csr_rx_invpolarity,
  output logic [`PCS8G_LANES-1:0]                   csr_rx_enapatternalign,
  output logic [`PCS8G_LANES-1:0]                   csr_rx_bitreversalenable,
  output logic [`PCS8G_LANES-1:0]                   csr_rx_bytereversalenable,
  output logic [`PCS8G_LANES-1:0]                   csr_rx_bitslip
);

  // flattened controls, still in the bus domain
  logic [`PCS8G_LANES-1:0]                   tx_inv_d;
  logic [`PCS8G_LANES*`PCS8G_BOUNDARY_W-1:0] tx_bnd_d;
  logic [`PCS8G_LANES-1:0]                   rx_inv_d;
  logic [`PCS8G_LANES-1:0]                   rx_pa_d;
  logic [`PCS8G_LANES-1:0]                   rx_bitrev_d;
  logic [`PCS8G_LANES-1:0]                   rx_byterev_d;
  logic [`PCS8G_LANES-1:0]                   rx_slip_d;

  // chains, [0] samples the bus-domain register
  logic [`PCS8G_LANES*(`PCS8G_BOUNDARY_W+1)-1:0] tx_sync [`PCS8G_SYNC_STAGES];
  logic [`PCS8G_LANES*5-1:0]                     rx_sync [`PCS8G_SYNC_STAGES];

  always_comb begin
    for (int i = 0; i < `PCS8G_LANES; i++) begin
      tx_inv_d[i]     = ctrl.lane[i].tx_invpolarity;
      tx_bnd_d[i*`PCS8G_BOUNDARY_W +: `PCS8G_BOUNDARY_W] = ctrl.lane[i].tx_boundary;
      rx_inv_d[i]     = ctrl.lane[i].rx_invpolarity;
      rx_pa_d[i]      = ctrl.lane[i].rx_enapatternalign;
      rx_bitrev_d[i]  = ctrl.lane[i].rx_bitreversal;
      rx_byterev_d[i] = ctrl.lane[i].rx_bytereversal;
      rx_slip_d[i]    = ctrl.lane[i].rx_bitslip;
    end
  end

  ////////////////////
  // tx_clk domain
  always_ff @(posedge tx_clk or posedge reset) begin
    if (reset) begin
      for (int s = 0; s < `PCS8G_SYNC_STAGES; s++)
        tx_sync[s] <= '0;
    end else begin
      tx_sync[0] <= {tx_bnd_d, tx_inv_d};
      for (int s = 1; s < `PCS8G_SYNC_STAGES; s++)
        tx_sync[s] <= tx_sync[s-1];
    end
  end

  assign {csr_tx_bitslipboundaryselect, csr_tx_invpolarity} = tx_sync[`PCS8G_SYNC_STAGES-1];

  ////////////////////
  // rx_clk domain
  always_ff @(posedge rx_clk or posedge reset) begin
    if (reset) begin
      for (int s = 0; s < `PCS8G_SYNC_STAGES; s++)
        rx_sync[s] <= '0;
    end else begin
      rx_sync[0] <= {rx_slip_d, rx_byterev_d, rx_bitrev_d, rx_pa_d, rx_inv_d};
      for (int s = 1; s < `PCS8G_SYNC_STAGES; s++)
        rx_sync[s] <= rx_sync[s-1];
    end
  end

  assign {csr_rx_bitslip, csr_rx_bytereversalenable, csr_rx_bitreversalenable,
          csr_rx_enapatternalign, csr_rx_invpolarity} = rx_sync[`PCS8G_SYNC_STAGES-1];

endmodule

//--- pcs8g_csr.sv
// pcs8g CSR top level
// lane-indexed control and status registers for a four-lane 8b/10b PCS
`include "pcs8g_macros.svh"

module pcs8g_csr (
  // host bus
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic [7:0]                              address,
  input  logic                                    read,
  output logic [31:0]                             readdata,
  input  logic                                    write,
  input  logic [31:0]                             writedata,

  input  logic                                    rx_clk,   // rx control outputs
  input  logic                                    tx_clk,   // tx control outputs

  // transceiver status, asynchronous to clk
  input  logic [`PCS8G_LANES*`PCS8G_WORDS-1:0]      rx_patterndetect,
  input  logic [`PCS8G_LANES*`PCS8G_WORDS-1:0]      rx_syncstatus,
  input  logic [`PCS8G_LANES*`PCS8G_WORDS-1:0]      rx_errdetect,
  input  logic [`PCS8G_LANES*`PCS8G_WORDS-1:0]      rx_disperr,
  input  logic [`PCS8G_LANES-1:0]                   rx_phase_comp_fifo_error,
  input  logic [`PCS8G_LANES-1:0]                   tx_phase_comp_fifo_error,
  input  logic [`PCS8G_LANES*`PCS8G_BOUNDARY_W-1:0] rx_bitslipboundaryselectout,
  input  logic [`PCS8G_LANES-1:0]                   rlv,

  // PCS controls
  output logic [`PCS8G_LANES-1:0]                   csr_tx_invpolarity,
  output logic [`PCS8G_LANES*`PCS8G_BOUNDARY_W-1:0] csr_tx_bitslipboundaryselect,
  output logic [`PCS8G_LANES-1:0]                   csr_rx_invpolarity,
  output logic [`PCS8G_LANES-1:0]                   csr_rx_enapatternalign,
  output logic [`PCS8G_LANES-1:0]                   csr_rx_bitreversalenable,
  output logic [`PCS8G_LANES-1:0]                   csr_rx_bytereversalenable,
  output logic [`PCS8G_LANES-1:0]                   csr_rx_bitslip
);

  pcs8g_ctrl_if   ctrl_if ();
  pcs8g_status_if status_if ();

  pcs8g_csr_regs u_regs (
    .clk       (clk),
    .reset     (reset),
    .address   (address),
    .read      (read),
    .write     (write),
    .writedata (writedata),
    .readdata  (readdata),
    .ctrl      (ctrl_if.regs),
    .status    (status_if.regs)
  );

  pcs8g_status_sync u_status (
    .clk                         (clk),
    .reset                       (reset),
    .rx_patterndetect            (rx_patterndetect),
    .rx_syncstatus               (rx_syncstatus),
    .rx_errdetect                (rx_errdetect),
    .rx_disperr                  (rx_disperr),
    .rx_phase_comp_fifo_error    (rx_phase_comp_fifo_error),
    .tx_phase_comp_fifo_error    (tx_phase_comp_fifo_error),
    .rlv                         (rlv),
    .rx_bitslipboundaryselectout (rx_bitslipboundaryselectout),
    .status                      (status_if.sync)
  );

  pcs8g_ctrl_cdc u_cdc (
    .tx_clk                       (tx_clk),
    .rx_clk                       (rx_clk),
    .reset                        (reset),
    .ctrl                         (ctrl_if.cdc),
    .csr_tx_invpolarity           (csr_tx_invpolarity),
    .csr_tx_bitslipboundaryselect (csr_tx_bitslipboundaryselect),
    .csr_rx_invpolarity           (csr_rx_invpolarity),
    .csr_rx_enapatternalign       (csr_rx_enapatternalign),
    .csr_rx_bitreversalenable     (csr_rx_bitreversalenable),
    .csr_rx_bytereversalenable    (csr_rx_bytereversalenable),
    .csr_rx_bitslip               (csr_rx_bitslip)
  );

endmodule

//--- tb_clock_gen.sv
// testbench clock and reset
// 100 unit clock period, reset held high for the first five cycles
module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    #10 reset = 1'b0;  // released clear of the edge
  end

endmodule

//--- tb_pcs8g_csr.sv
// pcs8g CSR testbench
// applies a table of bus and status rows and checks them against a shadow model
`include "pcs8g_macros.svh"

module tb_pcs8g_csr;

  localparam int LANES      = `PCS8G_LANES;
  localparam int CLK_PERIOD = 100;
  localparam int ROW_CYCLES = 5;  // worst row, status hold

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_ST, OP_OUT} op_e;

  typedef struct packed {
    op_e         op;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [63:0] exp;  // readdata, status pattern or packed csr_ outputs
  } row_t;

  logic        clk;
  logic        reset;
  logic [7:0]  address;
  logic        read;
  logic        write;
  logic [31:0] writedata;
  logic [31:0] readdata;
  // status pattern: errdetect 7:0, syncstatus 15:8, disperr 23:16, patterndetect 31:24,
  // boundary 51:32, rx fifo 55:52, tx fifo 59:56, rlv 63:60
  logic [63:0] st_bus;
  logic [7:0]  rx_errdetect;
  logic [7:0]  rx_syncstatus;
  logic [7:0]  rx_disperr;
  logic [7:0]  rx_patterndetect;
  logic [3:0]  rx_phase_comp_fifo_error;
  logic [3:0]  tx_phase_comp_fifo_error;
  logic [3:0]  rlv;
  logic [19:0] rx_bitslipboundaryselectout;
  logic [3:0]  csr_tx_invpolarity;
  logic [19:0] csr_tx_bitslipboundaryselect;
  logic [3:0]  csr_rx_invpolarity;
  logic [3:0]  csr_rx_enapatternalign;
  logic [3:0]  csr_rx_bitreversalenable;
  logic [3:0]  csr_rx_bytereversalenable;
  logic [3:0]  csr_rx_bitslip;

  row_t        rows[$];
  bit          table_ready;
  int          errors;
  integer      seed;
  logic [4:0]  m_lane;          // shadow lane index
  logic [63:0] m_status;        // shadow of st_bus
  logic [5:0]  m_tx [LANES];    // {boundary, invpolarity}
  logic        m_rxinv [LANES];
  logic [3:0]  m_wa [LANES];    // {bitslip, bytereversal, bitreversal, patternalign}

  assign {rlv, tx_phase_comp_fifo_error, rx_phase_comp_fifo_error, rx_bitslipboundaryselectout,
          rx_patterndetect, rx_disperr, rx_syncstatus, rx_errdetect} = st_bus;

  tb_clock_gen u_clk (.clk(clk), .reset(reset));

  pcs8g_csr dut0 (.rx_clk(clk), .tx_clk(clk), .*);  // both domains on the bus clock

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  ////////////////////
  // shadow model
  function automatic logic [31:0] exp_read(input logic [7:0] addr);
    logic [31:0] w;
    int          l;
    logic        ok;
    l  = int'(m_lane);
    ok = (l < LANES);  // out of range lane reads zero
    w  = 32'h0;
    case (addr)
      `PCS8G_ADDR_LANE:       w[4:0] = m_lane;
      `PCS8G_ADDR_RX_STATUS:  if (ok) w[5:0] = {m_status[32+l*5 +: 5], m_status[52+l]};
      `PCS8G_ADDR_TX_STATUS:  if (ok) w[0] = m_status[56+l];
      `PCS8G_ADDR_TX_CTRL:    if (ok) w[5:0] = m_tx[l];
      `PCS8G_ADDR_RX_CTRL:    if (ok) w[0] = m_rxinv[l];
      `PCS8G_ADDR_RX_WA_CTRL: if (ok) w[3:0] = m_wa[l];
      `PCS8G_ADDR_RX_WA_STATUS: begin
        if (ok) begin
          w[1:0]   = m_status[l*2 +: 2];     // two words at the bottom of each nibble
          w[5:4]   = m_status[8+l*2 +: 2];
          w[9:8]   = m_status[16+l*2 +: 2];
          w[13:12] = m_status[24+l*2 +: 2];
          w[16]    = m_status[60+l];
        end
      end
      default: w = 32'hFFFF_FFFF;  // unmapped
    endcase
    return w;
  endfunction

  // packed as tx inv 3:0, tx boundary 23:4, rx inv 27:24, then pa, bitrev, byterev, slip
  function automatic logic [63:0] model_outputs();
    logic [63:0] o;
    o = 64'h0;
    for (int i = 0; i < LANES; i++) begin
      o[i]          = m_tx[i][0];
      o[4+i*5 +: 5] = m_tx[i][5:1];
      o[24+i]       = m_rxinv[i];
      o[28+i]       = m_wa[i][0];
      o[32+i]       = m_wa[i][1];
      o[36+i]       = m_wa[i][2];
      o[40+i]       = m_wa[i][3];
    end
    return o;
  endfunction

  task automatic add_write(input logic [7:0] addr, input logic [31:0] data);
    int l;
    l = int'(m_lane);
    rows.push_back('{OP_WR, addr, data, 64'h0});
    case (addr)
      `PCS8G_ADDR_LANE:       m_lane = data[4:0];
      `PCS8G_ADDR_TX_CTRL:    if (l < LANES) m_tx[l] = data[5:0];
      `PCS8G_ADDR_RX_CTRL:    if (l < LANES) m_rxinv[l] = data[0];
      `PCS8G_ADDR_RX_WA_CTRL: if (l < LANES) m_wa[l] = data[3:0];
      default: ;  // read-only and unmapped, nothing changes
    endcase
  endtask

  task automatic expect_read(input logic [7:0] addr);
    rows.push_back('{OP_RD, addr, 32'h0, {32'h0, exp_read(addr)}});
  endtask

  task automatic set_status(input logic [63:0] pattern);
    m_status = pattern;
    rows.push_back('{OP_ST, 8'h0, 32'h0, pattern});
  endtask

  task automatic expect_outputs();
    rows.push_back('{OP_OUT, 8'h0, 32'h0, model_outputs()});
  endtask

  task automatic read_lane_regs();
    for (int a = `PCS8G_ADDR_RX_STATUS; a <= `PCS8G_ADDR_RX_WA_STATUS; a++)
      expect_read(8'(a));
  endtask

  ////////////////////
  // stimulus table
  task automatic build_table();
    logic [4:0] idx;
    logic [7:0] unmapped [4];
    unmapped = '{8'h00, 8'h07, 8'h0F, 8'hFF};
    expect_outputs();  // reset values
    expect_read(`PCS8G_ADDR_LANE);
    read_lane_regs();
    for (int l = 0; l < LANES; l++) begin
      add_write(`PCS8G_ADDR_LANE, l);
      add_write(`PCS8G_ADDR_TX_CTRL, $random(seed));
      add_write(`PCS8G_ADDR_RX_CTRL, $random(seed));
      add_write(`PCS8G_ADDR_RX_WA_CTRL, $random(seed));
      read_lane_regs();
      expect_outputs();  // lanes not yet written stay zero
    end
    for (int p = 0; p < 2; p++) begin
      set_status({$random(seed), $random(seed)});
      for (int l = 0; l < LANES; l++) begin
        add_write(`PCS8G_ADDR_LANE, l);
        read_lane_regs();
      end
    end
    add_write(`PCS8G_ADDR_LANE, $random(seed));
    expect_read(`PCS8G_ADDR_LANE);
    for (int k = 0; k < 2; k++) begin
      idx = (k == 0) ? 5'd4 : 5'd31;  // just past the last lane, and the top index
      add_write(`PCS8G_ADDR_LANE, ($random(seed) & 32'hFFFF_FFE0) | idx);
      expect_read(`PCS8G_ADDR_LANE);
      read_lane_regs();
      for (int a = `PCS8G_ADDR_TX_CTRL; a <= `PCS8G_ADDR_RX_WA_CTRL; a++)
        add_write(8'(a), $random(seed));
      expect_outputs();
    end
    // a real lane is selected so that a stray unmapped write would show
    add_write(`PCS8G_ADDR_LANE, 2);
    for (int k = 0; k < 4; k++) begin
      expect_read(unmapped[k]);
      add_write(unmapped[k], $random(seed));
    end
    add_write(`PCS8G_ADDR_RX_STATUS, $random(seed));
    add_write(`PCS8G_ADDR_TX_STATUS, $random(seed));
    add_write(`PCS8G_ADDR_RX_WA_STATUS, $random(seed));
    expect_outputs();
    expect_read(`PCS8G_ADDR_LANE);
    read_lane_regs();
  endtask

  task automatic apply_row(input row_t r);
    case (r.op)
      OP_WR: begin
        address   = r.addr;
        writedata = r.data;
        write     = 1'b1;
        @(posedge clk);
        #10 write = 1'b0;
      end
      OP_RD: begin
        address = r.addr;
        read    = 1'b1;
        @(posedge clk);  // readdata loads here
        #10 read = 1'b0;
        compare_value($sformatf("readdata[%02h]", r.addr), readdata, r.exp);
      end
      OP_ST: begin
        st_bus = r.exp;
        repeat (4) @(posedge clk);  // sync chain plus slack
        #10;
      end
      default: begin
        repeat (2) @(posedge clk);
        #10;
        compare_value("csr_tx_invpolarity", csr_tx_invpolarity, r.exp[3:0]);
        compare_value("csr_tx_bitslipboundaryselect", csr_tx_bitslipboundaryselect,
                      r.exp[23:4]);
        compare_value("csr_rx_invpolarity", csr_rx_invpolarity, r.exp[27:24]);
        compare_value("csr_rx_enapatternalign", csr_rx_enapatternalign, r.exp[31:28]);
        compare_value("csr_rx_bitreversalenable", csr_rx_bitreversalenable, r.exp[35:32]);
        compare_value("csr_rx_bytereversalenable", csr_rx_bytereversalenable, r.exp[39:36]);
        compare_value("csr_rx_bitslip", csr_rx_bitslip, r.exp[43:40]);
      end
    endcase
  endtask

  initial begin : main
    address   = 8'h0;
    read      = 1'b0;
    write     = 1'b0;
    writedata = 32'h0;
    st_bus    = 64'h0;
    errors    = 0;
    seed      = 32'h62db_fdef;
    m_lane    = 5'd0;
    m_status  = 64'h0;
    for (int i = 0; i < LANES; i++) begin
      m_tx[i]    = 6'h0;
      m_rxinv[i] = 1'b0;
      m_wa[i]    = 4'h0;
    end
    build_table();
    table_ready = 1'b1;
    @(negedge reset);
    @(posedge clk);
    #10;
    foreach (rows[i])
      apply_row(rows[i]);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = (10 + rows.size() * ROW_CYCLES + 20) * CLK_PERIOD;  // reset, rows, margin
    #(limit);
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired, the run did not finish within %0d time units", limit);
  end

endmodule

//--- sim.f
+incdir+.
pcs8g_pkg.sv
pcs8g_if.sv
pcs8g_csr_regs.sv
pcs8g_status_sync.sv
pcs8g_ctrl_cdc.sv
pcs8g_csr.sv
tb_clock_gen.sv
tb_pcs8g_csr.sv

//--- Bender.yml
package:
  name: pcs8g_csr

export_include_dirs:
  - .

sources:
  - pcs8g_pkg.sv
  - pcs8g_if.sv
  - pcs8g_csr_regs.sv
  - pcs8g_status_sync.sv
  - pcs8g_ctrl_cdc.sv
  - pcs8g_csr.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_pcs8g_csr.sv
